//--- rsBranchStation.f
+incdir+src
src/rsBrPkg.sv
src/rsBrOperandWakeup.sv
src/rsBrEntryQueue.sv
src/rsBranchStation.sv
tb/rsBrProps.sv
tb/tbRsBranchStation.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch station testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tbRsBranchStation -Mdir "$BUILD" \
    -f rsBranchStation.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/VtbRsBranchStation" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- src/rsBrEntryQueue.sv
`timescale 1ns/1ns
`include "rs_br_defines.svh"

module rsBrEntryQueue (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               predictResult,
    input  rsBrPkg::brPayload_t                dispPayload,
    input  logic                               headReady,
    output rsBrPkg::rsIdx_t                    head,
    output rsBrPkg::rsIdx_t                    tail,
    output logic                               issueFire,
    output logic                               issueValid,
    output logic                               issueBranch,
    output logic                               issueJump,
    output logic                               issueHit,
    output logic                               issueTaken,
    output rsBrPkg::physTag_t                  issuePhy,
    output rsBrPkg::word_t                     issueInstNum,
    output logic [`RS_BR_FUNCT3_W-1:0]         issueFunct3,
    output rsBrPkg::word_t                     issueImm,
    output rsBrPkg::word_t                     issuePc
);
    import rsBrPkg::*;

    brPayload_t entries [`RS_BR_DEPTH];  // payload ram
    brPayload_t issueQ;                  // registered issue stage

    // no downstream stall, a ready head always goes
    assign issueFire = headReady;

    // payload write at the tail
    always_ff @(posedge clk) begin
        if (start && !predictResult) begin
            entries[tail] <= dispPayload;
        end
    end

    // pointers and issue register
    always_ff @(posedge clk) begin
        if (reset || predictResult) begin
            head       <= '0;
            tail       <= '0;
            issueValid <= 1'b0;
            issueQ     <= '0;
        end else begin
            if (start) begin
                tail <= tail + 1'b1;  // wraps at depth
            end

            if (issueFire) begin
                head       <= head + 1'b1;
                issueValid <= 1'b1;
                issueQ     <= entries[head];
            end else begin
                // outputs read as zero between issues
                issueValid <= 1'b0;
                issueQ     <= '0;
            end
        end
    end

    assign issueBranch  = issueQ.isBranch;
    assign issueJump    = issueQ.isJump;
    assign issueHit     = issueQ.predHit;
    assign issueTaken   = issueQ.predTaken;
    assign issuePhy     = issueQ.rd;         // destination of the branch (link reg)
    assign issueInstNum = issueQ.instNum;
    assign issueFunct3  = issueQ.funct3;
    assign issueImm     = issueQ.immediate;
    assign issuePc      = issueQ.pc;

endmodule

//--- src/rsBrOperandWakeup.sv
`timescale 1ns/1ns
`include "rs_br_defines.svh"

module rsBrOperandWakeup (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       start,
    input  logic                                       predictResult,
    input  rsBrPkg::physTag_t                          op1Tag,
    input  rsBrPkg::physTag_t                          op2Tag,
    input  logic [1:0]                                 opValid,
    input  rsBrPkg::physTag_t [`RS_BR_NUM_SRC-1:0]     srcTag,
    input  logic [`RS_BR_NUM_SRC-1:0]                  srcValid,
    input  rsBrPkg::rsIdx_t                            head,
    input  rsBrPkg::rsIdx_t                            tail,
    input  logic                                       issueFire,
    output logic                                       headReady
);
    import rsBrPkg::*;

    // source tags per entry
    physTag_t tag1 [`RS_BR_DEPTH];
    physTag_t tag2 [`RS_BR_DEPTH];

    logic [`RS_BR_DEPTH-1:0] busy;   // slot holds a live instruction
    logic [`RS_BR_DEPTH-1:0] rdy1;
    logic [`RS_BR_DEPTH-1:0] rdy2;

    logic [1:0] dispReady;           // operand readiness at dispatch

    // true when any valid broadcast this cycle carries the given tag
    function automatic logic tagHit(physTag_t tag);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < `RS_BR_NUM_SRC; s++) begin
            if (srcValid[s] && srcTag[s] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // bypass, each operand matched on its own against every source
    always_comb begin
        dispReady[0] = opValid[0] | tagHit(op1Tag);
        dispReady[1] = opValid[1] | tagHit(op2Tag);
    end

    // only the head is ever considered for issue
    assign headReady = busy[head] & rdy1[head] & rdy2[head];

    // ready and occupancy state
    always_ff @(posedge clk) begin
        if (reset || predictResult) begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            // wakeup of resident entries
            for (int e = 0; e < `RS_BR_DEPTH; e++) begin
                if (busy[e] && tagHit(tag1[e])) begin
                    rdy1[e] <= 1'b1;
                end
                if (busy[e] && tagHit(tag2[e])) begin
                    rdy2[e] <= 1'b1;
                end
            end

            if (issueFire) begin  // entry leaves the station
                busy[head] <= 1'b0;
                rdy1[head] <= 1'b0;
                rdy2[head] <= 1'b0;
            end

            if (start) begin
                busy[tail] <= 1'b1;
                rdy1[tail] <= dispReady[0];
                rdy2[tail] <= dispReady[1];
            end
        end
    end

    // tag storage, stale tags are masked by busy
    always_ff @(posedge clk) begin
        if (issueFire) begin
            tag1[head] <= '0;
            tag2[head] <= '0;
        end
        if (start) begin
            tag1[tail] <= op1Tag;
            tag2[tail] <= op2Tag;
        end
    end

endmodule

//--- src/rsBrPkg.sv
`include "rs_br_defines.svh"

package rsBrPkg;

    typedef logic [`RS_BR_IDX_W-1:0]  rsIdx_t;    // queue slot
    typedef logic [`RS_BR_TAG_W-1:0]  physTag_t;  // physical register
    typedef logic [`RS_BR_WORD_W-1:0] word_t;

    // everything an entry carries to the branch unit
    typedef struct packed {
        word_t                       instNum;
        word_t                       pc;
        word_t                       immediate;
        physTag_t                    rd;
        logic [`RS_BR_FUNCT3_W-1:0]  funct3;
        logic                        isJump;
        logic                        isBranch;
        logic                        predTaken;  // front end guessed taken
        logic                        predHit;    // btb hit at fetch
    } brPayload_t;

    // slot order of the result broadcast arrays
    typedef enum logic [2:0] {
        srcAlu,
        srcMul,
        srcDiv,
        srcLoad,
        srcBr
    } wakeSrc_e;

endpackage

//--- src/rsBranchStation.sv
`timescale 1ns/1ns
`include "rs_br_defines.svh"

module rsBranchStation (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               predictResult,   // mispredict flush
    input  rsBrPkg::word_t                     instNum,
    input  rsBrPkg::word_t                     pc,
    input  rsBrPkg::word_t                     imm,
    input  rsBrPkg::physTag_t                  rd,
    input  rsBrPkg::physTag_t                  op1Tag,
    input  rsBrPkg::physTag_t                  op2Tag,
    input  logic [`RS_BR_FUNCT3_W-1:0]         funct3,
    input  logic [1:0]                         opValid,
    input  logic                               isJump,
    input  logic                               isBranch,
    input  logic                               predTaken,
    input  logic                               predHit,
    input  rsBrPkg::physTag_t                  aluTag,
    input  logic                               aluValid,
    input  rsBrPkg::physTag_t                  mulTag,
    input  logic                               mulValid,
    input  rsBrPkg::physTag_t                  divTag,
    input  logic                               divValid,
    input  rsBrPkg::physTag_t                  loadTag,
    input  logic                               memRead,
    input  rsBrPkg::physTag_t                  brTag,
    input  logic                               brDone,
    output logic                               issueValid,
    output logic                               issueBranch,
    output logic                               issueJump,
    output logic                               issueHit,
    output logic                               issueTaken,
    output rsBrPkg::physTag_t                  issuePhy,
    output rsBrPkg::word_t                     issueInstNum,
    output logic [`RS_BR_FUNCT3_W-1:0]         issueFunct3,
    output rsBrPkg::word_t                     issueImm,
    output rsBrPkg::word_t                     issuePc
);
    import rsBrPkg::*;

    brPayload_t dispPayload;

    physTag_t [`RS_BR_NUM_SRC-1:0] srcTag;
    logic [`RS_BR_NUM_SRC-1:0]     srcValid;

    rsIdx_t head;
    rsIdx_t tail;
    logic   headReady;
    logic   issueFire;

    always_comb begin
        dispPayload.instNum   = instNum;
        dispPayload.pc        = pc;
        dispPayload.immediate = imm;
        dispPayload.rd        = rd;
        dispPayload.funct3    = funct3;
        dispPayload.isJump    = isJump;
        dispPayload.isBranch  = isBranch;
        dispPayload.predTaken = predTaken;
        dispPayload.predHit   = predHit;
    end

    // result broadcasts into slot order
    assign srcTag[srcAlu]    = aluTag;
    assign srcTag[srcMul]    = mulTag;
    assign srcTag[srcDiv]    = divTag;
    assign srcTag[srcLoad]   = loadTag;
    assign srcTag[srcBr]     = brTag;
    assign srcValid[srcAlu]  = aluValid;
    assign srcValid[srcMul]  = mulValid;
    assign srcValid[srcDiv]  = divValid;
    assign srcValid[srcLoad] = memRead;   // load data valid when the read completes
    assign srcValid[srcBr]   = brDone;

    rsBrOperandWakeup u_operandWakeup (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .predictResult (predictResult),
        .op1Tag        (op1Tag),
        .op2Tag        (op2Tag),
        .opValid       (opValid),
        .srcTag        (srcTag),
        .srcValid      (srcValid),
        .head          (head),
        .tail          (tail),
        .issueFire     (issueFire),
        .headReady     (headReady)
    );

    rsBrEntryQueue u_entryQueue (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .predictResult (predictResult),
        .dispPayload   (dispPayload),
        .headReady     (headReady),
        .head          (head),
        .tail          (tail),
        .issueFire     (issueFire),
        .issueValid    (issueValid),
        .issueBranch   (issueBranch),
        .issueJump     (issueJump),
        .issueHit      (issueHit),
        .issueTaken    (issueTaken),
        .issuePhy      (issuePhy),
        .issueInstNum  (issueInstNum),
        .issueFunct3   (issueFunct3),
        .issueImm      (issueImm),
        .issuePc       (issuePc)
    );

endmodule

//--- src/rs_br_defines.svh
`ifndef RS_BR_DEFINES_SVH
`define RS_BR_DEFINES_SVH

// queue geometry, depth must stay a power of two for pointer wrap
`define RS_BR_DEPTH     64
`define RS_BR_IDX_W     6

// physical register tag
`define RS_BR_TAG_W     8

// pc, immediate and instruction number
`define RS_BR_WORD_W    32

// branch condition code
`define RS_BR_FUNCT3_W  3

// alu, mul, div, load, branch
`define RS_BR_NUM_SRC   5

`endif

//--- tb/rsBrProps.sv
`timescale 1ns/1ns
`include "rs_br_defines.svh"

module rsBrProps (
    input logic                          clk,
    input logic                          reset,
    input logic                          predictResult,
    input logic                          issueValid,
    input logic                          issueBranch,
    input logic                          issueJump,
    input logic                          issueHit,
    input logic                          issueTaken,
    input logic [`RS_BR_TAG_W-1:0]       issuePhy,
    input logic [`RS_BR_WORD_W-1:0]      issueInstNum,
    input logic [`RS_BR_FUNCT3_W-1:0]    issueFunct3,
    input logic [`RS_BR_WORD_W-1:0]      issueImm,
    input logic [`RS_BR_WORD_W-1:0]      issuePc
);

    logic anyField;  // some issue field is nonzero

    assign anyField = issueBranch | issueJump | issueHit | issueTaken | (|issuePhy)
                    | (|issueInstNum) | (|issueFunct3) | (|issueImm) | (|issuePc);

    idleFieldsZero: assert property (@(posedge clk) disable iff (reset)
        !issueValid |-> !anyField)
        else $error("issue fields nonzero while issueValid is low");

    // flush wins over a ready head
    flushBlocksIssue: assert property (@(posedge clk) disable iff (reset)
        predictResult |=> !issueValid)
        else $error("entry issued in the cycle after a flush");

    quietAtResetExit: assert property (@(posedge clk) $fell(reset) |-> !issueValid)
        else $error("issueValid high when reset drops");

    quietAfterResetExit: assert property (@(posedge clk) $fell(reset) |=> !issueValid)
        else $error("issueValid high one cycle after reset");

endmodule

bind rsBranchStation rsBrProps u_props (
    .clk           (clk),
    .reset         (reset),
    .predictResult (predictResult),
    .issueValid    (issueValid),
    .issueBranch   (issueBranch),
    .issueJump     (issueJump),
    .issueHit      (issueHit),
    .issueTaken    (issueTaken),
    .issuePhy      (issuePhy),
    .issueInstNum  (issueInstNum),
    .issueFunct3   (issueFunct3),
    .issueImm      (issueImm),
    .issuePc       (issuePc)
);

//--- tb/tbRsBranchStation.sv
`timescale 1ns/1ns
`include "rs_br_defines.svh"

module tbRsBranchStation;

    localparam int CLK_PERIOD = 40;
    localparam int STIM_DELAY = 5;
    localparam int MAX_STEPS  = 256;
    localparam int DEPTH      = `RS_BR_DEPTH;
    localparam int NUM_SRC    = `RS_BR_NUM_SRC;

    logic                        clk;
    logic                        reset;
    logic                        start;
    logic                        predictResult;
    logic [`RS_BR_WORD_W-1:0]    instNum;
    logic [`RS_BR_WORD_W-1:0]    pc;
    logic [`RS_BR_WORD_W-1:0]    imm;
    logic [`RS_BR_TAG_W-1:0]     rd;
    logic [`RS_BR_TAG_W-1:0]     op1Tag;
    logic [`RS_BR_TAG_W-1:0]     op2Tag;
    logic [`RS_BR_FUNCT3_W-1:0]  funct3;
    logic [1:0]                  opValid;
    logic                        isJump;
    logic                        isBranch;
    logic                        predTaken;
    logic                        predHit;
    logic [`RS_BR_TAG_W-1:0]     aluTag;
    logic                        aluValid;
    logic [`RS_BR_TAG_W-1:0]     mulTag;
    logic                        mulValid;
    logic [`RS_BR_TAG_W-1:0]     divTag;
    logic                        divValid;
    logic [`RS_BR_TAG_W-1:0]     loadTag;
    logic                        memRead;
    logic [`RS_BR_TAG_W-1:0]     brTag;
    logic                        brDone;
    logic                        issueValid;
    logic                        issueBranch;
    logic                        issueJump;
    logic                        issueHit;
    logic                        issueTaken;
    logic [`RS_BR_TAG_W-1:0]     issuePhy;
    logic [`RS_BR_WORD_W-1:0]    issueInstNum;
    logic [`RS_BR_FUNCT3_W-1:0]  issueFunct3;
    logic [`RS_BR_WORD_W-1:0]    issueImm;
    logic [`RS_BR_WORD_W-1:0]    issuePc;

    // one stimulus row per clock
    logic        tStart    [MAX_STEPS];
    logic        tFlush    [MAX_STEPS];
    logic [1:0]  tOpValid  [MAX_STEPS];
    logic [7:0]  tOp1Tag   [MAX_STEPS];
    logic [7:0]  tOp2Tag   [MAX_STEPS];
    logic [4:0]  tSrcValid [MAX_STEPS];     // alu mul div load br
    logic [7:0]  tSrcTag   [MAX_STEPS][NUM_SRC];
    logic [31:0] tInstNum  [MAX_STEPS];
    logic [31:0] tPc       [MAX_STEPS];
    logic [31:0] tImm      [MAX_STEPS];
    logic [7:0]  tRd       [MAX_STEPS];
    logic [2:0]  tFunct3   [MAX_STEPS];
    logic [3:0]  tFlags    [MAX_STEPS];     // jump branch taken hit
    // expected columns
    logic        eValid    [MAX_STEPS];
    int          eStep     [MAX_STEPS];     // row whose payload issues

    // reference queue
    logic        mBusy [DEPTH];
    logic        mRdy1 [DEPTH];
    logic        mRdy2 [DEPTH];
    logic [7:0]  mTag1 [DEPTH];
    logic [7:0]  mTag2 [DEPTH];
    int          mStep [DEPTH];

    int     nSteps;
    integer seed;
    logic   tableReady = 1'b0;

    rsBranchStation u_rsBranchStation (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic broadcastMatches(input int k, input logic [7:0] tag);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (tSrcValid[k][s] && tSrcTag[k][s] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic addStep(input logic st, input logic [1:0] opv, input logic [7:0] t1,
                           input logic [7:0] t2, input logic fl);
        tStart[nSteps]    = st;
        tFlush[nSteps]    = fl;
        tOpValid[nSteps]  = opv;
        tOp1Tag[nSteps]   = t1;
        tOp2Tag[nSteps]   = t2;
        tSrcValid[nSteps] = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            tSrcTag[nSteps][s] = 8'($random(seed));  // noise on idle buses
        end
        tInstNum[nSteps] = $random(seed);
        tPc[nSteps]      = $random(seed);
        tImm[nSteps]     = $random(seed);
        tRd[nSteps]      = 8'($random(seed));
        tFunct3[nSteps]  = 3'($random(seed));
        tFlags[nSteps]   = 4'($random(seed));
        nSteps++;
    endtask

    // attach a result broadcast to the newest row
    task automatic addBroadcast(input int src, input logic [7:0] tag, input logic strobe);
        tSrcTag[nSteps-1][src]   = tag;
        tSrcValid[nSteps-1][src] = strobe;
    endtask

    task automatic dispatchReady();
        addStep(1'b1, 2'b11, 8'($random(seed)), 8'($random(seed)), 1'b0);
    endtask

    task automatic idleSteps(input int n);
        repeat (n) addStep(1'b0, 2'b00, 8'h00, 8'h00, 1'b0);
    endtask

    task automatic buildTable();
        logic [7:0] tag;
        nSteps = 0;
        // plain in-order issue
        repeat (6) dispatchReady();
        idleSteps(2);
        // blocked head woken by each source in turn
        for (int s = 0; s < NUM_SRC; s++) begin
            tag = 8'h10 + 8'(s);
            addStep(1'b1, (s % 2 == 0) ? 2'b10 : 2'b01, tag, tag, 1'b0);
            dispatchReady();
            dispatchReady();
            idleSteps(1);
            addBroadcast(s, tag, 1'b0);  // low strobe must not wake
            idleSteps(1);
            idleSteps(1);
            addBroadcast(s, tag, 1'b1);
            idleSteps(3);
        end
        // same-cycle bypass at dispatch
        addStep(1'b1, 2'b10, 8'h40, 8'h00, 1'b0);
        addBroadcast(0, 8'h40, 1'b1);
        addStep(1'b1, 2'b00, 8'h50, 8'h51, 1'b0);
        addBroadcast(1, 8'h50, 1'b1);
        addBroadcast(4, 8'h51, 1'b1);
        addStep(1'b1, 2'b01, 8'h00, 8'h41, 1'b0);
        addBroadcast(3, 8'h41, 1'b0);    // load tag without memRead
        dispatchReady();
        idleSteps(3);
        idleSteps(1);
        addBroadcast(2, 8'h41, 1'b1);
        idleSteps(3);
        // mispredict flush
        addStep(1'b1, 2'b10, 8'h60, 8'h60, 1'b0);
        dispatchReady();
        dispatchReady();
        idleSteps(1);
        addStep(1'b1, 2'b11, 8'h00, 8'h00, 1'b1);  // dispatch dropped by flush
        idleSteps(1);
        addBroadcast(0, 8'h60, 1'b1);
        idleSteps(2);
        dispatchReady();
        addStep(1'b0, 2'b00, 8'h00, 8'h00, 1'b1);  // ready head flushed
        idleSteps(1);
        repeat (3) dispatchReady();
        idleSteps(2);
        // deep queue across the pointer wrap
        addStep(1'b1, 2'b01, 8'h00, 8'h70, 1'b0);
        repeat (40) dispatchReady();
        dispatchReady();
        addBroadcast(4, 8'h70, 1'b1);
        repeat (40) dispatchReady();
        idleSteps(46);
    endtask

    task automatic clearModel();
        for (int e = 0; e < DEPTH; e++) begin
            mBusy[e] = 1'b0;
            mRdy1[e] = 1'b0;
            mRdy2[e] = 1'b0;
        end
    endtask

    // in-order issue rules applied row by row
    task automatic predictIssues();
        int   head;
        int   tail;
        logic headRdy;
        clearModel();
        head = 0;
        tail = 0;
        for (int k = 0; k < nSteps; k++) begin
            headRdy   = mBusy[head] && mRdy1[head] && mRdy2[head];
            eValid[k] = 1'b0;
            eStep[k]  = -1;
            if (tFlush[k]) begin
                clearModel();
                head = 0;
                tail = 0;
            end else begin
                for (int e = 0; e < DEPTH; e++) begin
                    if (mBusy[e] && broadcastMatches(k, mTag1[e])) begin
                        mRdy1[e] = 1'b1;
                    end
                    if (mBusy[e] && broadcastMatches(k, mTag2[e])) begin
                        mRdy2[e] = 1'b1;
                    end
                end
                if (headRdy) begin
                    eValid[k]   = 1'b1;
                    eStep[k]    = mStep[head];
                    mBusy[head] = 1'b0;
                    head        = (head + 1) % DEPTH;
                end
                if (tStart[k]) begin
                    mBusy[tail] = 1'b1;
                    mRdy1[tail] = tOpValid[k][0] | broadcastMatches(k, tOp1Tag[k]);
                    mRdy2[tail] = tOpValid[k][1] | broadcastMatches(k, tOp2Tag[k]);
                    mTag1[tail] = tOp1Tag[k];
                    mTag2[tail] = tOp2Tag[k];
                    mStep[tail] = k;
                    tail        = (tail + 1) % DEPTH;
                end
            end
        end
    endtask

    task automatic driveStep(input int k);
        start         = tStart[k];
        predictResult = tFlush[k];
        opValid       = tOpValid[k];
        op1Tag        = tOp1Tag[k];
        op2Tag        = tOp2Tag[k];
        instNum       = tInstNum[k];
        pc            = tPc[k];
        imm           = tImm[k];
        rd            = tRd[k];
        funct3        = tFunct3[k];
        {isJump, isBranch, predTaken, predHit} = tFlags[k];
        aluTag   = tSrcTag[k][0];
        aluValid = tSrcValid[k][0];
        mulTag   = tSrcTag[k][1];
        mulValid = tSrcValid[k][1];
        divTag   = tSrcTag[k][2];
        divValid = tSrcValid[k][2];
        loadTag  = tSrcTag[k][3];
        memRead  = tSrcValid[k][3];
        brTag    = tSrcTag[k][4];
        brDone   = tSrcValid[k][4];
    endtask

    task automatic compareValue(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (got !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // all fields read zero when nothing issues
    task automatic checkIssue(input logic valid, input int s);
        logic [31:0] expInst;
        logic [31:0] expPc;
        logic [31:0] expImm;
        logic [7:0]  expRd;
        logic [2:0]  expFunct3;
        logic [3:0]  expFlags;
        expInst   = '0;
        expPc     = '0;
        expImm    = '0;
        expRd     = '0;
        expFunct3 = '0;
        expFlags  = '0;
        if (valid) begin
            expInst   = tInstNum[s];
            expPc     = tPc[s];
            expImm    = tImm[s];
            expRd     = tRd[s];
            expFunct3 = tFunct3[s];
            expFlags  = tFlags[s];
        end
        compareValue("issueValid", 32'(valid), 32'(issueValid));
        compareValue("issueInstNum", expInst, issueInstNum);
        compareValue("issuePc", expPc, issuePc);
        compareValue("issueImm", expImm, issueImm);
        compareValue("issuePhy", 32'(expRd), 32'(issuePhy));
        compareValue("issueFunct3", 32'(expFunct3), 32'(issueFunct3));
        compareValue("issueJump", 32'(expFlags[3]), 32'(issueJump));
        compareValue("issueBranch", 32'(expFlags[2]), 32'(issueBranch));
        compareValue("issueTaken", 32'(expFlags[1]), 32'(issueTaken));
        compareValue("issueHit", 32'(expFlags[0]), 32'(issueHit));
    endtask

    initial begin
        seed  = 56064;
        reset = 1'b1;
        addStep(1'b0, 2'b00, 8'h00, 8'h00, 1'b0);  // idle row driven during reset
        tSrcTag[0][0] = '0;
        tSrcTag[0][1] = '0;
        tSrcTag[0][2] = '0;
        tSrcTag[0][3] = '0;
        tSrcTag[0][4] = '0;
        driveStep(0);
        buildTable();
        predictIssues();
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        #(STIM_DELAY);
        reset = 1'b0;
        checkIssue(1'b0, -1);
        for (int k = 0; k < nSteps; k++) begin
            driveStep(k);
            @(posedge clk);
            #(STIM_DELAY);
            checkIssue(eValid[k], eStep[k]);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // bound scales with table length
    initial begin
        wait (tableReady);
        #((nSteps + DEPTH) * 4 * CLK_PERIOD);
        $display("timeout, issue never finished within %0d table steps", nSteps);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
